/* list.f */
src/core_types_pkg.sv
src/core_ctrl_pkg.sv
src/exec_bus_if.sv
src/insn_latch.sv
src/reg_list_pop.sv
src/core_control.sv
src/reg_alu.sv
src/exec_core.sv
bench/tb_exec_core.sv

/* run.sh */
#!/bin/bash
# Build and run the exec_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_exec_core -o sim_exec_core
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_exec_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* bench/tb_exec_core.sv */
`timescale 1ns/100ps

module tb_exec_core
	import core_types_pkg::*;
;

	localparam int NUM_INSNS = 1 + 2 + 41 + 41 + 16 + 21; // Per test with its closing store
	localparam int CYCLE_LIMIT = NUM_INSNS * 40;

	logic        clk, rst_n, insn_valid;
	alu_op       op;
	logic        is_ldst, load, ldst_writeback, use_imm, shift_by_reg;
	reg_num      rd, rn, rm, rs;
	logic [11:0] imm;
	logic [4:0]  shift_imm;
	reg_list     regs;
	logic        stall, mem_ready, mem_start, mem_write;
	word         mem_data_rd, mem_data_wr;
	ptr          mem_addr;

	int  seed = 32'h4119a128;
	int  errors = 0;
	int  cycles = 0;
	bit  slow = 0;
	bit  busy = 0;
	int  wait_left;
	word mem [64];   // Memory seen by the DUT
	word mmem [64];  // Model copy
	word mreg [16];
	ptr  exp_addr [$];
	word exp_data [$];
	bit  exp_write [$];

	exec_core dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	function automatic word rand_word();
		return $random(seed);
	endfunction

	function automatic word shifted(word b, int amount);
		return amount >= 32 ? 32'd0 : b << amount; // Zero from 32 up
	endfunction

	// Memory model answering each start after a random wait
	initial begin
		mem_ready = 1'b0;
		mem_data_rd = '0;
		forever begin
			@(posedge clk);
			#2;
			if (mem_ready) begin
				mem_ready = 1'b0;
				busy = 0;
			end
			if (mem_start) begin
				if (busy) begin
					$display("Memory start while the previous access is still open");
					errors++;
				end
				busy = 1;
				wait_left = slow ? 3 + (rand_word() & 3) : rand_word() & 3;
			end
			if (busy && wait_left == 0) begin
				mem_ready = 1'b1;
				if (exp_addr.size() == 0) begin
					$display("Memory access that no accepted instruction asked for");
					errors++;
				end else begin
					assert (mem_addr == exp_addr[0])
					else begin
						$display("Error: mem_addr got %h expected %h", mem_addr, exp_addr[0]);
						errors++;
					end
					assert (mem_write == exp_write[0])
					else begin
						$display("Error: mem_write got %h expected %h", mem_write, exp_write[0]);
						errors++;
					end
					if (exp_write[0]) begin
						assert (mem_data_wr == exp_data[0])
						else begin
							$display("Error: mem_data_wr got %h expected %h",
								mem_data_wr, exp_data[0]);
							errors++;
						end
					end
					void'(exp_addr.pop_front());
					void'(exp_data.pop_front());
					void'(exp_write.pop_front());
				end
				if (mem_write)
					mem[mem_addr[5:0]] = mem_data_wr;
				else
					mem_data_rd = mem[mem_addr[5:0]];
			end else if (busy) begin
				wait_left--;
			end
		end
	end

	task automatic apply_model();
		word base, b, a;
		ptr  addr;
		int  cnt, amount;
		if (is_ldst) begin
			base = mreg[rn];
			cnt = 0;
			for (int i = 0; i < 16; i++) begin
				if (regs[i]) begin
					addr = base[31:2] + ptr'(cnt);
					exp_addr.push_back(addr);
					exp_write.push_back(!load);
					exp_data.push_back(mreg[i]);
					if (load)
						mreg[i] = mmem[addr[5:0]];
					else
						mmem[addr[5:0]] = mreg[i];
					cnt++;
				end
			end
			if (ldst_writeback)
				mreg[rn] = base + word'(4 * cnt);
		end else begin
			amount = shift_by_reg ? int'(mreg[rs][7:0]) : int'(shift_imm);
			b = shifted(use_imm ? {20'd0, imm} : mreg[rm], amount);
			a = mreg[rn];
			case (op)
				ALU_ADD: mreg[rd] = a + b;
				ALU_SUB: mreg[rd] = a - b;
				ALU_AND: mreg[rd] = a & b;
				ALU_ORR: mreg[rd] = a | b;
				ALU_EOR: mreg[rd] = a ^ b;
				default: mreg[rd] = b;
			endcase
		end
	endtask

	// Present the fields already set and hold them until accepted
	task automatic issue_insn();
		bit accepted;
		apply_model();
		insn_valid = 1'b1;
		do begin
			@(negedge clk);
			accepted = !stall;
			@(posedge clk);
		end while (!accepted);
		#2;
		insn_valid = 1'b0;
	endtask

	task automatic send_alu(alu_op o, reg_num d, reg_num n, reg_num m, bit ui, logic [11:0] im,
			bit sbr, reg_num s, logic [4:0] sh);
		op = o;
		is_ldst = 1'b0;
		rd = d;
		rn = n;
		rm = m;
		use_imm = ui;
		imm = im;
		shift_by_reg = sbr;
		rs = s;
		shift_imm = sh;
		issue_insn();
	endtask

	task automatic send_multi(bit ld, bit wb, reg_num base, reg_list rl);
		is_ldst = 1'b1;
		load = ld;
		ldst_writeback = wb;
		rn = base;
		regs = rl;
		shift_by_reg = 1'b0;
		shift_imm = '0;
		issue_insn();
	endtask

	task automatic random_alu();
		word r;
		r = rand_word();
		send_alu(alu_op'(r[31:16] % 6), r[3:0], r[7:4], r[11:8], r[12], 12'(rand_word()),
			1'b0, '0, r[13] ? r[20:16] : 5'd0);
	endtask

	task automatic random_multi();
		word r;
		r = rand_word();
		send_multi(r[0], r[1], r[7:4], r[31:16]);
	endtask

	// Store every register and wait for the queue to drain
	task automatic finish_test(int num, string name, int err_start);
		send_multi(1'b0, 1'b0, reg_num'(num), 16'hffff);
		do
			@(posedge clk);
		while (exp_addr.size() != 0 || stall);
		#2;
		$display("Test %0d %s: %0d errors", num, name, errors - err_start);
	endtask

	initial begin
		int err_start;
		word r;
		rst_n = 1'b0;
		insn_valid = 1'b0;
		op = ALU_ADD;
		{is_ldst, load, ldst_writeback, use_imm, shift_by_reg} = '0;
		{rd, rn, rm, rs} = '0;
		imm = '0;
		shift_imm = '0;
		regs = '0;
		for (int i = 0; i < 16; i++)
			mreg[i] = '0;
		for (int i = 0; i < 64; i++) begin
			mem[i] = rand_word() ^ word'(i * 32'h01010101);
			mmem[i] = mem[i];
		end

		err_start = errors;
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;
		repeat (4) begin
			assert (!stall && !mem_start && !mem_write)
			else begin
				$display("Control outputs active after reset without an instruction");
				errors++;
			end
			@(posedge clk);
			#2;
		end
		finish_test(1, "reset and zero store", err_start);

		err_start = errors;
		send_multi(1'b1, 1'b0, 4'd0, 16'hffff);
		finish_test(2, "load then store multiple", err_start);

		err_start = errors;
		repeat (40)
			random_alu();
		finish_test(3, "random ALU", err_start);

		err_start = errors;
		repeat (20) begin
			r = rand_word();
			case (r[1:0])
				2'd0: imm = 12'd0;
				2'd1: imm = 12'd32 + 12'(r[15:8]);
				default: imm = 12'(r[12:8]);
			endcase
			send_alu(ALU_MOV, r[19:16], 4'd0, 4'd0, 1'b1, imm, 1'b0, '0, '0);
			send_alu(alu_op'(r[31:24] % 6), r[23:20], r[27:24], 4'(rand_word()), r[2],
				12'(rand_word()), 1'b1, r[19:16], '0);
		end
		finish_test(4, "shift by register", err_start);

		err_start = errors;
		repeat (15)
			random_multi();
		finish_test(5, "random multiple transfers", err_start);

		err_start = errors;
		slow = 1;
		repeat (10) begin
			random_multi();
			random_alu();
		end
		finish_test(6, "back-pressure", err_start);
		slow = 0;

		$display("Tests done: 6 run, %0d errors, %0d cycles", errors, cycles);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* src/exec_core.sv */
`timescale 1ns/100ps

module exec_core
	import core_types_pkg::*;
	import core_ctrl_pkg::*;
(
	input  logic        clk,
	                    rst_n,
	                    insn_valid,
	input  alu_op       op,
	input  logic        is_ldst,
	                    load,
	                    ldst_writeback,
	input  reg_num      rd,
	                    rn,
	                    rm,
	                    rs,
	input  logic        use_imm,
	input  logic [11:0] imm,
	input  logic        shift_by_reg,
	input  logic [4:0]  shift_imm,
	input  reg_list     regs,
	output logic        stall,
	input  logic        mem_ready,
	input  word         mem_data_rd,
	output ptr          mem_addr,
	output word         mem_data_wr,
	output logic        mem_start,
	                    mem_write
);

	issued_insn insn_in, insn;
	logic       take, pending;

	exec_bus_if bus ();

	assign insn_in = '{
		op: op, is_ldst: is_ldst, load: load, ldst_writeback: ldst_writeback,
		rd: rd, rn: rn, rm: rm, rs: rs,
		use_imm: use_imm, imm: imm,
		shift_by_reg: shift_by_reg, shift_imm: shift_imm,
		regs: regs
	};

	insn_latch latch_i (
		.clk(clk),
		.rst_n(rst_n),
		.insn_valid(insn_valid),
		.insn_in(insn_in),
		.take(take),
		.stall(stall),
		.pending(pending),
		.insn(insn)
	);

	core_control control_i (
		.clk(clk),
		.rst_n(rst_n),
		.pending(pending),
		.insn(insn),
		.take(take),
		.bus(bus.ctrl),
		.mem_ready(mem_ready),
		.mem_data_rd(mem_data_rd),
		.mem_addr(mem_addr),
		.mem_data_wr(mem_data_wr),
		.mem_start(mem_start),
		.mem_write(mem_write)
	);

	reg_alu unit_i (
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus.unit)
	);

endmodule

/* src/reg_alu.sv */
`timescale 1ns/100ps

module reg_alu
	import core_types_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	exec_bus_if.unit bus
);

	word regs_q [16];
	word operand, b_op;

	assign bus.rd_value_a = regs_q[bus.ra];
	assign bus.rd_value_b = regs_q[bus.rb];

	always_comb begin
		operand = bus.use_imm ? {20'd0, bus.imm} : bus.rd_value_b;
		b_op = bus.b_override ? bus.b_value : operand << bus.shift; // Zero from 32 up

		case (bus.op)
			ALU_ADD: bus.q_alu = bus.rd_value_a + b_op;
			ALU_SUB: bus.q_alu = bus.rd_value_a - b_op;
			ALU_AND: bus.q_alu = bus.rd_value_a & b_op;
			ALU_ORR: bus.q_alu = bus.rd_value_a | b_op;
			ALU_EOR: bus.q_alu = bus.rd_value_a ^ b_op;
			default: bus.q_alu = b_op;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++)
				regs_q[i] <= '0;
		end else if (bus.wr_en) begin
			regs_q[bus.rd] <= bus.wr_value;
		end
	end

	write_rd_known: assert property (
		@(posedge clk) disable iff (!rst_n) bus.wr_en |-> !$isunknown(bus.rd)
	) else $error("register write with unknown rd");

endmodule

/* src/core_control.sv */
`timescale 1ns/100ps

module core_control
	import core_types_pkg::*;
	import core_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       pending,
	input  issued_insn insn,
	output logic       take,
	exec_bus_if.ctrl   bus,
	input  logic       mem_ready,
	input  word        mem_data_rd,
	output ptr         mem_addr,
	output word        mem_data_wr,
	output logic       mem_start,
	output logic       mem_write
);

	ctrl_cycle  cycle, next_cycle;
	issued_insn cur;
	logic       live;      // cur holds an instruction not yet finished
	word        saved;     // Shifted operand, or next transfer address
	shift_amt   amt, shift_sel;
	logic       mem_open, advance, pop_valid;
	reg_list    list, pop_next;
	reg_num     popped, xfer_rd;

	reg_list_pop pop_i (
		.regs(list),
		.valid(pop_valid),
		.next(pop_next),
		.pop(popped)
	);

	assign advance = ~mem_open | mem_ready;
	assign take = pending && cycle == ISSUE && next_cycle == ISSUE;

	always_comb begin
		shift_sel = cycle == RD_INDIRECT_SHIFT ? amt : {3'b000, cur.shift_imm};

		next_cycle = ISSUE;
		case (cycle)
			ISSUE:
				if (live) begin
					if (cur.is_ldst)
						next_cycle = TRANSFER;
					else if (cur.shift_by_reg)
						next_cycle = RD_INDIRECT_SHIFT;
					else if (shift_sel != 0)
						next_cycle = WITH_SHIFT;
				end

			RD_INDIRECT_SHIFT:
				if (shift_sel != 0)
					next_cycle = WITH_SHIFT;

			TRANSFER:
				if (pop_valid || !advance)
					next_cycle = TRANSFER;
				else if (cur.ldst_writeback)
					next_cycle = BASE_WRITEBACK;

			default: ;
		endcase
	end

	always_comb begin
		bus.ra = cur.rn;
		bus.rb = cur.rm;
		bus.rd = cur.rd;
		bus.op = cur.op;
		bus.use_imm = cur.use_imm;
		bus.imm = cur.imm;
		bus.shift = shift_sel;
		bus.b_override = 1'b0;
		bus.b_value = saved;
		bus.wr_value = bus.q_alu;
		bus.wr_en = 1'b0;

		case (cycle)
			ISSUE: begin
				if (cur.shift_by_reg)
					bus.rb = cur.rs; // Fetch the amount first
				else if (shift_sel != 0)
					bus.op = ALU_MOV;
				bus.wr_en = live && !cur.is_ldst && !cur.shift_by_reg && shift_sel == 0;
			end

			RD_INDIRECT_SHIFT: begin
				if (shift_sel != 0)
					bus.op = ALU_MOV;
				bus.wr_en = shift_sel == 0;
			end

			WITH_SHIFT: begin
				bus.b_override = 1'b1;
				bus.wr_en = 1'b1;
			end

			TRANSFER: begin
				bus.rb = popped; // Store data for the next access
				bus.rd = xfer_rd;
				bus.wr_value = mem_data_rd;
				bus.wr_en = mem_open && mem_ready && cur.load;
			end

			BASE_WRITEBACK: begin
				bus.rd = cur.rn;
				bus.wr_value = saved;
				bus.wr_en = 1'b1;
			end

			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cycle <= ISSUE;
			live <= 1'b0;
			mem_open <= 1'b0;
			mem_start <= 1'b0;
			mem_write <= 1'b0;
		end else begin
			cycle <= next_cycle;
			mem_start <= 1'b0;

			if (next_cycle == ISSUE)
				live <= take;

			if (cycle == TRANSFER && advance) begin
				mem_open <= pop_valid;
				mem_start <= pop_valid;
				mem_write <= pop_valid & ~cur.load;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			cur <= insn;

		case (cycle)
			ISSUE: begin
				amt <= bus.rd_value_b[7:0];
				saved <= cur.is_ldst ? bus.rd_value_a : bus.q_alu;
				list <= cur.regs;
			end

			RD_INDIRECT_SHIFT:
				saved <= bus.q_alu;

			TRANSFER:
				if (advance && pop_valid) begin
					mem_addr <= saved[31:2];
					mem_data_wr <= bus.rd_value_b;
					saved <= saved + 32'd4;
					list <= pop_next;
					xfer_rd <= popped;
				end

			default: ;
		endcase
	end

	// No new start and a steady request until the open access is answered
	hold_while_open: assert property (
		@(posedge clk) disable iff (!rst_n)
		mem_open && !mem_ready |=> !mem_start && $stable(mem_addr) && $stable(mem_write)
			&& $stable(mem_data_wr)
	) else $error("memory request changed while an access is open");

	ready_when_open: assert property (
		@(posedge clk) disable iff (!rst_n) mem_ready |-> mem_open
	) else $error("mem_ready without an open access");

endmodule

/* src/reg_list_pop.sv */
`timescale 1ns/100ps

module reg_list_pop
	import core_types_pkg::*;
(
	input  reg_list regs,
	output logic    valid,
	output reg_list next,
	output reg_num  pop
);

	always_comb begin
		valid = |regs;
		next = regs & (regs - reg_list'(1)); // Lowest set bit cleared

		// Scan downwards so the lowest hit wins
		pop = '0;
		for (int i = 15; i >= 0; i--) begin
			if (regs[i])
				pop = reg_num'(i);
		end

		if (valid) begin
			assert (regs[pop] && !next[pop])
			else $error("popped r%0d does not match list %h", pop, regs);
		end
	end

endmodule

/* src/insn_latch.sv */
`timescale 1ns/100ps

module insn_latch
	import core_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       insn_valid,
	input  issued_insn insn_in,
	input  logic       take,
	output logic       stall,
	output logic       pending,
	output issued_insn insn
);

	logic accept;

	assign stall = pending & ~take;
	assign accept = insn_valid & ~stall; // Refill allowed on the take edge

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pending <= 1'b0;
		else if (accept)
			pending <= 1'b1;
		else if (take)
			pending <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (accept)
			insn <= insn_in;
	end

	take_needs_pending: assert property (
		@(posedge clk) disable iff (!rst_n) take |-> pending
	) else $error("take without a pending instruction");

endmodule

/* src/exec_bus_if.sv */
`timescale 1ns/100ps

interface exec_bus_if;

	import core_types_pkg::*;

	reg_num      ra, rb, rd;
	logic        wr_en;
	word         wr_value;
	alu_op       op;
	logic        use_imm;
	logic [11:0] imm;
	logic        b_override; // b_value replaces the shifted operand
	word         b_value;
	shift_amt    shift;
	word         rd_value_a, rd_value_b, q_alu;

	modport ctrl (
		output ra, rb, rd, wr_en, wr_value, op, use_imm, imm, b_override, b_value, shift,
		input  rd_value_a, rd_value_b, q_alu
	);

	modport unit (
		input  ra, rb, rd, wr_en, wr_value, op, use_imm, imm, b_override, b_value, shift,
		output rd_value_a, rd_value_b, q_alu
	);

endinterface

/* src/core_ctrl_pkg.sv */
package core_ctrl_pkg;

	import core_types_pkg::*;

	typedef enum logic [2:0] {
		ISSUE,
		RD_INDIRECT_SHIFT,
		WITH_SHIFT,
		TRANSFER,
		BASE_WRITEBACK
	} ctrl_cycle;

	// Decoded instruction as held by the latch and the control
	typedef struct packed {
		alu_op       op;
		logic        is_ldst;
		logic        load;
		logic        ldst_writeback;
		reg_num      rd;
		reg_num      rn;
		reg_num      rm;
		reg_num      rs;
		logic        use_imm;
		logic [11:0] imm;
		logic        shift_by_reg;
		logic [4:0]  shift_imm;
		reg_list     regs;
	} issued_insn;

endpackage

/* src/core_types_pkg.sv */
package core_types_pkg;

	typedef logic [31:0] word;
	typedef logic [3:0]  reg_num;
	typedef logic [15:0] reg_list; // One bit per register
	typedef logic [29:0] ptr;      // Word address
	typedef logic [7:0]  shift_amt;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_ORR,
		ALU_EOR,
		ALU_MOV // Second operand only
	} alu_op;

endpackage
